// ==== common/mshr_cfg_pkg.sv ====
package mshr_cfg_pkg;

    // ==============================
    // entry and buffer sizing
    // ==============================
    localparam int MSHR_ENTRY_NUM = 8;
    localparam int MSHR_IDX_W     = $clog2(MSHR_ENTRY_NUM);

    localparam int LFDB_ENTRY_NUM = 16;    // linefill data buffer slots
    localparam int LFDB_IDX_W     = $clog2(LFDB_ENTRY_NUM);

    // ==============================
    // address and id fields
    // ==============================
    localparam int TAG_W    = 20;
    localparam int SET_W    = 8;
    localparam int WAY_W    = 2;
    localparam int TXN_ID_W = 6;

endpackage

// ==== common/mshr_types_pkg.sv ====
package mshr_types_pkg;

    typedef logic [mshr_cfg_pkg::MSHR_IDX_W-1:0]     entry_idx_t;
    typedef logic [mshr_cfg_pkg::MSHR_ENTRY_NUM-1:0] entry_vec_t;    // one bit per entry
    typedef logic [mshr_cfg_pkg::LFDB_IDX_W-1:0]     lfdb_idx_t;

    typedef logic [mshr_cfg_pkg::TAG_W-1:0]    tag_t;
    typedef logic [mshr_cfg_pkg::SET_W-1:0]    set_t;
    typedef logic [mshr_cfg_pkg::WAY_W-1:0]    way_t;
    typedef logic [mshr_cfg_pkg::TXN_ID_W-1:0] txn_id_t;

    // lookup result written into a reserved entry
    typedef struct packed {
        entry_idx_t rob_entry_id;
        logic       is_hit;
        tag_t       tag;
        set_t       set;
        way_t       way;
        txn_id_t    txn_id;
    } mshr_update_t;

    // data ram read or linefill write
    typedef struct packed {
        txn_id_t    txn_id;
        set_t       set;
        way_t       way;
        lfdb_idx_t  db_entry_id;
        entry_idx_t rob_entry_id;
    } ram_cmd_t;

    typedef struct packed {
        txn_id_t    txn_id;
        tag_t       tag;
        set_t       set;
        way_t       way;
        lfdb_idx_t  db_entry_id;
        entry_idx_t rob_entry_id;
    } ds_req_t;

    typedef enum logic [2:0] {
        IDLE,
        RESERVED,
        MISS_REQ,
        WAIT_FILL,     // line requested, waiting for downstream data
        LF_WR_REQ,
        WAIT_LF_WR,
        RD_REQ,
        WAIT_RD_DONE
    } entry_state_e;

endpackage

// ==== common/mshr_event_if.sv ====
// one-hot event strobes, decoder to entries
interface mshr_event_if;

    mshr_types_pkg::entry_vec_t update_en;
    mshr_types_pkg::entry_vec_t ds_done;
    mshr_types_pkg::entry_vec_t lf_done;
    mshr_types_pkg::entry_vec_t rd_done;
    mshr_types_pkg::lfdb_idx_t  ds_done_db_id;    // shared by all entries

    modport src (
        output update_en,
        output ds_done,
        output lf_done,
        output rd_done,
        output ds_done_db_id
    );

    modport dst (
        input  update_en,
        input  ds_done,
        input  lf_done,
        input  rd_done,
        input  ds_done_db_id
    );

endinterface

// ==== hdl/rr_arb.sv ====
module rr_arb #(
    parameter int WIDTH     = 8,
    parameter int PLD_WIDTH = 32
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [WIDTH-1:0]                  v_vld_s,
    input  logic [WIDTH-1:0][PLD_WIDTH-1:0]   v_pld_s,
    output logic [WIDTH-1:0]                  v_rdy_s,
    output logic                              vld_m,
    output logic [PLD_WIDTH-1:0]              pld_m,
    input  logic                              rdy_m
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [IDX_W-1:0] ptr;        // highest priority requester
    logic [IDX_W-1:0] win_idx;
    logic             found;

    // search from ptr upward, wrapping
    always_comb begin
        int cand;
        found   = 1'b0;
        win_idx = '0;
        for (int k = 0; k < WIDTH; k++) begin
            cand = (int'(ptr) + k) % WIDTH;
            if (!found && v_vld_s[cand]) begin
                found   = 1'b1;
                win_idx = IDX_W'(cand);
            end
        end
    end

    assign vld_m   = found;
    assign pld_m   = v_pld_s[win_idx];
    assign v_rdy_s = (found && rdy_m) ? (WIDTH'(1) << win_idx) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (found && rdy_m) begin
            ptr <= (int'(win_idx) == WIDTH - 1) ? '0 : win_idx + 1'b1;    // move past winner
        end
    end

endmodule

// ==== hdl/mshr_event_decode.sv ====
module mshr_event_decode (
    input  logic                        update_en,
    input  mshr_types_pkg::entry_idx_t  update_idx,
    input  logic                        ds_done,
    input  mshr_types_pkg::entry_idx_t  ds_done_idx,
    input  mshr_types_pkg::lfdb_idx_t   ds_done_db_id,
    input  logic                        lf_done,
    input  mshr_types_pkg::entry_idx_t  lf_done_idx,
    input  logic                        rd_done,
    input  mshr_types_pkg::entry_idx_t  rd_done_idx,
    mshr_event_if.src                   ev
);

    // strobe plus index to one-hot entry vector
    function automatic mshr_types_pkg::entry_vec_t onehot(
        input logic                       en,
        input mshr_types_pkg::entry_idx_t idx
    );
        onehot      = '0;
        onehot[idx] = en;
    endfunction

    assign ev.update_en     = onehot(update_en, update_idx);
    assign ev.ds_done       = onehot(ds_done,   ds_done_idx);
    assign ev.lf_done       = onehot(lf_done,   lf_done_idx);
    assign ev.rd_done       = onehot(rd_done,   rd_done_idx);
    assign ev.ds_done_db_id = ds_done_db_id;

endmodule

// ==== mshr/mshr_pre_alloc.sv ====
module mshr_pre_alloc (
    input  logic                        clk,
    input  logic                        arst_n,
    input  mshr_types_pkg::entry_vec_t  v_free,
    output logic                        alloc_vld,
    output mshr_types_pkg::entry_idx_t  alloc_idx,
    input  logic                        alloc_rdy,
    output mshr_types_pkg::entry_vec_t  v_grant
);

    mshr_types_pkg::entry_vec_t cand;
    mshr_types_pkg::entry_idx_t nxt_idx;
    logic                       nxt_vld;

    // granted entry still looks free this cycle
    assign cand = v_free & ~v_grant;

    always_comb begin
        nxt_vld = 1'b0;
        nxt_idx = '0;
        for (int i = mshr_cfg_pkg::MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (cand[i]) begin
                nxt_vld = 1'b1;
                nxt_idx = mshr_types_pkg::entry_idx_t'(i);    // lowest wins
            end
        end
    end

    assign v_grant = (alloc_vld && alloc_rdy) ? (mshr_types_pkg::entry_vec_t'(1) << alloc_idx) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_vld <= 1'b0;
        end else if (!alloc_vld || alloc_rdy) begin
            alloc_vld <= nxt_vld;
        end
    end

    // offer held until taken
    always_ff @(posedge clk) begin
        if (!alloc_vld || alloc_rdy) begin
            alloc_idx <= nxt_idx;
        end
    end

endmodule

// ==== mshr/vec_cache_mshr_entry.sv ====
module vec_cache_mshr_entry (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          grant,
    output logic                          free,
    input  mshr_types_pkg::mshr_update_t  update_pld,
    mshr_event_if.dst                     ev,
    input  mshr_types_pkg::entry_idx_t    entry_id,
    output logic                          miss_vld,
    output mshr_types_pkg::ds_req_t       miss_pld,
    input  logic                          miss_rdy,
    output logic                          lf_wr_vld,
    output mshr_types_pkg::ram_cmd_t      lf_wr_pld,
    input  logic                          lf_wr_rdy,
    output logic                          rd_vld,
    output mshr_types_pkg::ram_cmd_t      rd_pld,
    input  logic                          rd_rdy
);

    mshr_types_pkg::entry_state_e state;
    mshr_types_pkg::entry_state_e state_nxt;

    mshr_types_pkg::tag_t      tag_q;
    mshr_types_pkg::set_t      set_q;
    mshr_types_pkg::way_t      way_q;
    mshr_types_pkg::txn_id_t   txn_id_q;
    mshr_types_pkg::lfdb_idx_t db_id_q;
    mshr_types_pkg::ram_cmd_t  cmd_pld;

    logic upd_en;
    logic ds_done;
    logic lf_done;
    logic rd_done;

    assign upd_en  = ev.update_en[entry_id];
    assign ds_done = ev.ds_done[entry_id];
    assign lf_done = ev.lf_done[entry_id];
    assign rd_done = ev.rd_done[entry_id];

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            mshr_types_pkg::IDLE:         if (grant)     state_nxt = mshr_types_pkg::RESERVED;
            mshr_types_pkg::RESERVED: begin
                if (upd_en) begin
                    state_nxt = update_pld.is_hit ? mshr_types_pkg::RD_REQ
                                                  : mshr_types_pkg::MISS_REQ;
                end
            end
            mshr_types_pkg::MISS_REQ:     if (miss_rdy)  state_nxt = mshr_types_pkg::WAIT_FILL;
            mshr_types_pkg::WAIT_FILL:    if (ds_done)   state_nxt = mshr_types_pkg::LF_WR_REQ;
            mshr_types_pkg::LF_WR_REQ:    if (lf_wr_rdy) state_nxt = mshr_types_pkg::WAIT_LF_WR;
            mshr_types_pkg::WAIT_LF_WR:   if (lf_done)   state_nxt = mshr_types_pkg::RD_REQ;
            mshr_types_pkg::RD_REQ:       if (rd_rdy)    state_nxt = mshr_types_pkg::WAIT_RD_DONE;
            mshr_types_pkg::WAIT_RD_DONE: if (rd_done)   state_nxt = mshr_types_pkg::IDLE;
            default:                                     state_nxt = mshr_types_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mshr_types_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==============================
    // stored request
    // ==============================
    always_ff @(posedge clk) begin
        if (state == mshr_types_pkg::RESERVED && upd_en) begin
            tag_q    <= update_pld.tag;
            set_q    <= update_pld.set;
            way_q    <= update_pld.way;
            txn_id_q <= update_pld.txn_id;
            db_id_q  <= '0;                   // hits never use a buffer slot
        end else if (state == mshr_types_pkg::WAIT_FILL && ds_done) begin
            db_id_q  <= ev.ds_done_db_id;
        end
    end

    assign free      = (state == mshr_types_pkg::IDLE);
    assign miss_vld  = (state == mshr_types_pkg::MISS_REQ);
    assign lf_wr_vld = (state == mshr_types_pkg::LF_WR_REQ);
    assign rd_vld    = (state == mshr_types_pkg::RD_REQ);

    assign miss_pld = '{txn_id: txn_id_q, tag: tag_q, set: set_q, way: way_q,
                        db_entry_id: db_id_q, rob_entry_id: entry_id};

    // same command fields for linefill write and read
    assign cmd_pld   = '{txn_id: txn_id_q, set: set_q, way: way_q,
                         db_entry_id: db_id_q, rob_entry_id: entry_id};
    assign lf_wr_pld = cmd_pld;
    assign rd_pld    = cmd_pld;

endmodule

// ==== mshr/mshr_miss_issue.sv ====
module mshr_miss_issue (
    input  logic                                                       clk,
    input  logic                                                       arst_n,
    input  mshr_types_pkg::entry_vec_t                                 v_miss_vld,
    input  mshr_types_pkg::ds_req_t [mshr_cfg_pkg::MSHR_ENTRY_NUM-1:0] v_miss_pld,
    output mshr_types_pkg::entry_vec_t                                 v_miss_rdy,
    output logic                                                       downstream_txreq_vld,
    output mshr_types_pkg::ds_req_t                                    downstream_txreq_pld,
    input  logic                                                       downstream_txreq_rdy,
    input  logic                                                       linefill_alloc_vld,
    input  mshr_types_pkg::lfdb_idx_t                                  linefill_alloc_idx,
    output logic                                                       linefill_alloc_rdy
);

    logic                    arb_vld;
    logic                    arb_rdy;
    mshr_types_pkg::ds_req_t arb_pld;

    rr_arb #(
        .WIDTH     (mshr_cfg_pkg::MSHR_ENTRY_NUM),
        .PLD_WIDTH ($bits(mshr_types_pkg::ds_req_t))
    ) u_miss_arb (
        .clk     (clk),
        .arst_n  (arst_n),
        .v_vld_s (v_miss_vld),
        .v_pld_s (v_miss_pld),
        .v_rdy_s (v_miss_rdy),
        .vld_m   (arb_vld),
        .pld_m   (arb_pld),
        .rdy_m   (arb_rdy)
    );

    // no buffer slot, no request
    assign downstream_txreq_vld = arb_vld && linefill_alloc_vld;
    assign arb_rdy              = downstream_txreq_rdy && linefill_alloc_vld;
    assign linefill_alloc_rdy   = downstream_txreq_vld && downstream_txreq_rdy;

    always_comb begin
        downstream_txreq_pld             = arb_pld;
        downstream_txreq_pld.db_entry_id = linefill_alloc_idx;    // slot from allocator
    end

endmodule

// ==== mshr/vec_cache_mshr.sv ====
module vec_cache_mshr (
    input  logic                          clk,
    input  logic                          arst_n,
    output logic                          alloc_vld,
    output mshr_types_pkg::entry_idx_t    alloc_idx,
    input  logic                          alloc_rdy,
    input  logic                          mshr_update_en,
    input  mshr_types_pkg::mshr_update_t  mshr_update_pld,
    output logic                          downstream_txreq_vld,
    output mshr_types_pkg::ds_req_t       downstream_txreq_pld,
    input  logic                          downstream_txreq_rdy,
    input  logic                          linefill_alloc_vld,
    input  mshr_types_pkg::lfdb_idx_t     linefill_alloc_idx,
    output logic                          linefill_alloc_rdy,
    input  logic                          ds_txreq_done,
    input  mshr_types_pkg::entry_idx_t    ds_txreq_done_idx,
    input  mshr_types_pkg::lfdb_idx_t     ds_txreq_done_db_entry_id,
    input  logic                          linefill_done,
    input  mshr_types_pkg::entry_idx_t    linefill_done_idx,
    input  logic                          rd_done,
    input  mshr_types_pkg::entry_idx_t    rd_done_idx,
    output logic                          read_cmd_vld,
    output mshr_types_pkg::ram_cmd_t      read_cmd_pld,
    input  logic                          read_cmd_rdy,
    output logic                          write_cmd_vld_linefill,
    output mshr_types_pkg::ram_cmd_t      write_cmd_pld_linefill,
    input  logic                          write_cmd_rdy_linefill
);

    localparam int N = mshr_cfg_pkg::MSHR_ENTRY_NUM;

    mshr_types_pkg::entry_vec_t          v_free, v_grant;
    mshr_types_pkg::entry_vec_t          v_miss_vld, v_miss_rdy;
    mshr_types_pkg::entry_vec_t          v_lf_wr_vld, v_lf_wr_rdy;
    mshr_types_pkg::entry_vec_t          v_rd_vld, v_rd_rdy;
    mshr_types_pkg::ds_req_t  [N-1:0]    v_miss_pld;
    mshr_types_pkg::ram_cmd_t [N-1:0]    v_lf_wr_pld;
    mshr_types_pkg::ram_cmd_t [N-1:0]    v_rd_pld;

    mshr_event_if ev ();

    mshr_event_decode u_event_decode (
        .update_en     (mshr_update_en),
        .update_idx    (mshr_update_pld.rob_entry_id),
        .ds_done       (ds_txreq_done),
        .ds_done_idx   (ds_txreq_done_idx),
        .ds_done_db_id (ds_txreq_done_db_entry_id),
        .lf_done       (linefill_done),
        .lf_done_idx   (linefill_done_idx),
        .rd_done       (rd_done),
        .rd_done_idx   (rd_done_idx),
        .ev            (ev.src)
    );

    mshr_pre_alloc u_pre_alloc (
        .clk       (clk),
        .arst_n    (arst_n),
        .v_free    (v_free),
        .alloc_vld (alloc_vld),
        .alloc_idx (alloc_idx),
        .alloc_rdy (alloc_rdy),
        .v_grant   (v_grant)
    );

    // ==============================
    // entries
    // ==============================
    for (genvar i = 0; i < N; i++) begin : g_entry
        vec_cache_mshr_entry u_entry (
            .clk        (clk),
            .arst_n     (arst_n),
            .grant      (v_grant[i]),
            .free       (v_free[i]),
            .update_pld (mshr_update_pld),
            .ev         (ev.dst),
            .entry_id   (mshr_types_pkg::entry_idx_t'(i)),
            .miss_vld   (v_miss_vld[i]),
            .miss_pld   (v_miss_pld[i]),
            .miss_rdy   (v_miss_rdy[i]),
            .lf_wr_vld  (v_lf_wr_vld[i]),
            .lf_wr_pld  (v_lf_wr_pld[i]),
            .lf_wr_rdy  (v_lf_wr_rdy[i]),
            .rd_vld     (v_rd_vld[i]),
            .rd_pld     (v_rd_pld[i]),
            .rd_rdy     (v_rd_rdy[i])
        );
    end

    // ==============================
    // arbiters
    // ==============================
    mshr_miss_issue u_miss_issue (
        .clk                  (clk),
        .arst_n               (arst_n),
        .v_miss_vld           (v_miss_vld),
        .v_miss_pld           (v_miss_pld),
        .v_miss_rdy           (v_miss_rdy),
        .downstream_txreq_vld (downstream_txreq_vld),
        .downstream_txreq_pld (downstream_txreq_pld),
        .downstream_txreq_rdy (downstream_txreq_rdy),
        .linefill_alloc_vld   (linefill_alloc_vld),
        .linefill_alloc_idx   (linefill_alloc_idx),
        .linefill_alloc_rdy   (linefill_alloc_rdy)
    );

    rr_arb #(.WIDTH(N), .PLD_WIDTH($bits(mshr_types_pkg::ram_cmd_t))) u_rd_arb (
        .clk     (clk),
        .arst_n  (arst_n),
        .v_vld_s (v_rd_vld),
        .v_pld_s (v_rd_pld),
        .v_rdy_s (v_rd_rdy),
        .vld_m   (read_cmd_vld),
        .pld_m   (read_cmd_pld),
        .rdy_m   (read_cmd_rdy)
    );

    rr_arb #(.WIDTH(N), .PLD_WIDTH($bits(mshr_types_pkg::ram_cmd_t))) u_lf_wr_arb (
        .clk     (clk),
        .arst_n  (arst_n),
        .v_vld_s (v_lf_wr_vld),
        .v_pld_s (v_lf_wr_pld),
        .v_rdy_s (v_lf_wr_rdy),
        .vld_m   (write_cmd_vld_linefill),
        .pld_m   (write_cmd_pld_linefill),
        .rdy_m   (write_cmd_rdy_linefill)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== tb/tb_vec_cache_mshr.sv ====
module tb_vec_cache_mshr;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 100;
    localparam int W_ALLOC    = 0;
    localparam int W_DS       = 1;
    localparam int W_LF_WR    = 2;
    localparam int W_RD       = 3;
    localparam int W_LF_RDY   = 4;
    localparam int DONE_DS    = 0;
    localparam int DONE_LF    = 1;
    localparam int DONE_RD    = 2;

    logic                         clk;
    logic                         arst_n;
    logic                         alloc_vld;
    mshr_types_pkg::entry_idx_t   alloc_idx;
    logic                         alloc_rdy;
    logic                         mshr_update_en;
    mshr_types_pkg::mshr_update_t mshr_update_pld;
    logic                         downstream_txreq_vld;
    mshr_types_pkg::ds_req_t      downstream_txreq_pld;
    logic                         downstream_txreq_rdy;
    logic                         linefill_alloc_vld;
    mshr_types_pkg::lfdb_idx_t    linefill_alloc_idx;
    logic                         linefill_alloc_rdy;
    logic                         ds_txreq_done;
    mshr_types_pkg::entry_idx_t   ds_txreq_done_idx;
    mshr_types_pkg::lfdb_idx_t    ds_txreq_done_db_entry_id;
    logic                         linefill_done;
    mshr_types_pkg::entry_idx_t   linefill_done_idx;
    logic                         rd_done;
    mshr_types_pkg::entry_idx_t   rd_done_idx;
    logic                         read_cmd_vld;
    mshr_types_pkg::ram_cmd_t     read_cmd_pld;
    logic                         read_cmd_rdy;
    logic                         write_cmd_vld_linefill;
    mshr_types_pkg::ram_cmd_t     write_cmd_pld_linefill;
    logic                         write_cmd_rdy_linefill;
    int                           errors;

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clk_gen (.clk(clk), .arst_n(arst_n));

    vec_cache_mshr u_vec_cache_mshr (.*);

    // ==============================
    // helpers
    // ==============================
    task automatic stop_on_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                                    $time, what, actual, expected));
        end
    endtask

    function automatic logic watched(input int sel);
        case (sel)
            W_ALLOC:  return alloc_vld;
            W_DS:     return downstream_txreq_vld;
            W_LF_WR:  return write_cmd_vld_linefill;
            W_RD:     return read_cmd_vld;
            W_LF_RDY: return linefill_alloc_rdy;
            default:  return 1'b0;
        endcase
    endfunction

    // returns on the falling edge where the signal is seen high
    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (n < WAIT_LIMIT && !watched(sel)) begin
            @(negedge clk);
            n++;
        end
        if (!watched(sel)) stop_on_error($sformatf("timed out waiting for %s", what));
    endtask

    function automatic mshr_types_pkg::mshr_update_t new_update(
        input mshr_types_pkg::entry_idx_t idx,
        input logic                       hit,
        input mshr_types_pkg::set_t       set_v,
        input mshr_types_pkg::way_t       way_v
    );
        mshr_types_pkg::mshr_update_t u;
        u.rob_entry_id = idx;
        u.is_hit       = hit;
        u.tag          = mshr_types_pkg::tag_t'($urandom);
        u.set          = set_v;
        u.way          = way_v;
        u.txn_id       = mshr_types_pkg::txn_id_t'($urandom);
        return u;
    endfunction

    task automatic send_update(input mshr_types_pkg::mshr_update_t upd);
        @(posedge clk);
        mshr_update_en  <= 1'b1;
        mshr_update_pld <= upd;
        @(posedge clk);
        mshr_update_en  <= 1'b0;
    endtask

    task automatic pulse_done(input int kind, input mshr_types_pkg::entry_idx_t idx,
                              input mshr_types_pkg::lfdb_idx_t db);
        @(posedge clk);
        case (kind)
            DONE_DS: begin
                ds_txreq_done             <= 1'b1;
                ds_txreq_done_idx         <= idx;
                ds_txreq_done_db_entry_id <= db;
            end
            DONE_LF: begin
                linefill_done     <= 1'b1;
                linefill_done_idx <= idx;
            end
            default: begin
                rd_done     <= 1'b1;
                rd_done_idx <= idx;
            end
        endcase
        @(posedge clk);
        ds_txreq_done <= 1'b0;
        linefill_done <= 1'b0;
        rd_done       <= 1'b0;
    endtask

    task automatic check_cmd(input mshr_types_pkg::ram_cmd_t got,
                             input mshr_types_pkg::mshr_update_t upd, input string what);
        check(got.txn_id, upd.txn_id, {what, " txn_id"});
        check(got.set, upd.set, {what, " set"});
        check(got.way, upd.way, {what, " way"});
        check(got.rob_entry_id, upd.rob_entry_id, {what, " rob_entry_id"});
    endtask

    task automatic check_ds_req(input mshr_types_pkg::mshr_update_t upd,
                                input mshr_types_pkg::lfdb_idx_t slot);
        check(downstream_txreq_pld.txn_id, upd.txn_id, "downstream txn_id");
        check(downstream_txreq_pld.tag, upd.tag, "downstream tag");
        check(downstream_txreq_pld.set, upd.set, "downstream set");
        check(downstream_txreq_pld.way, upd.way, "downstream way");
        check(downstream_txreq_pld.db_entry_id, slot, "downstream db_entry_id");
        check(downstream_txreq_pld.rob_entry_id, upd.rob_entry_id, "downstream rob_entry_id");
    endtask

    // entry freed, take it back so it is reserved again
    task automatic take_offer(input mshr_types_pkg::entry_idx_t idx);
        wait_for(W_ALLOC, "allocation offer");
        check(alloc_idx, idx, "offered alloc_idx");
        @(posedge clk);
        alloc_rdy <= 1'b1;
        @(posedge clk);
        alloc_rdy <= 1'b0;
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_allocation();
        logic [7:0] seen;
        int         count;
        int         n;
        seen  = '0;
        count = 0;
        n     = 0;
        @(posedge clk);
        alloc_rdy <= 1'b1;
        while (count < 8 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (alloc_vld) begin
                check(seen[alloc_idx], 1'b0, "repeated alloc_idx");
                seen[alloc_idx] = 1'b1;
                count++;
            end
        end
        check(count, 8, "number of allocation offers");
        repeat (20) begin
            @(negedge clk);
            check(alloc_vld, 1'b0, "alloc_vld with all entries taken");
        end
        @(posedge clk);
        alloc_rdy <= 1'b0;
    endtask

    task automatic test_hit_flow();
        mshr_types_pkg::mshr_update_t upd;
        upd = new_update(0, 1'b1, 8'h21, 2'd1);
        send_update(upd);
        wait_for(W_RD, "hit read command");
        check_cmd(read_cmd_pld, upd, "hit read");
        pulse_done(DONE_RD, 0, '0);
        take_offer(0);
    endtask

    task automatic test_miss_flow();
        mshr_types_pkg::mshr_update_t upd;
        mshr_types_pkg::lfdb_idx_t    slot;
        mshr_types_pkg::lfdb_idx_t    db;
        upd  = new_update(1, 1'b0, 8'h42, 2'd2);
        slot = mshr_types_pkg::lfdb_idx_t'($urandom);
        db   = mshr_types_pkg::lfdb_idx_t'($urandom);
        @(posedge clk);
        linefill_alloc_idx <= slot;
        send_update(upd);
        wait_for(W_DS, "downstream request");
        check_ds_req(upd, slot);
        check(linefill_alloc_rdy, 1'b1, "linefill_alloc_rdy on handshake");
        @(negedge clk);
        check(linefill_alloc_rdy, 1'b0, "linefill_alloc_rdy after handshake");
        pulse_done(DONE_DS, 1, db);
        wait_for(W_LF_WR, "linefill write command");
        check_cmd(write_cmd_pld_linefill, upd, "linefill write");
        check(write_cmd_pld_linefill.db_entry_id, db, "linefill write db_entry_id");
        pulse_done(DONE_LF, 1, '0);
        wait_for(W_RD, "read after linefill");
        check_cmd(read_cmd_pld, upd, "miss read");
        pulse_done(DONE_RD, 1, '0);
        take_offer(1);
    endtask

    task automatic test_back_pressure();
        mshr_types_pkg::mshr_update_t upd_a;
        mshr_types_pkg::mshr_update_t upd_b;
        mshr_types_pkg::lfdb_idx_t    slot_a;
        mshr_types_pkg::lfdb_idx_t    slot_b;
        upd_a  = new_update(2, 1'b0, 8'h63, 2'd3);
        upd_b  = new_update(3, 1'b0, 8'h64, 2'd0);
        slot_a = mshr_types_pkg::lfdb_idx_t'($urandom);
        slot_b = mshr_types_pkg::lfdb_idx_t'($urandom);
        @(posedge clk);
        downstream_txreq_rdy <= 1'b0;
        linefill_alloc_idx   <= slot_a;
        send_update(upd_a);
        wait_for(W_DS, "held downstream request");
        repeat (20) begin
            @(negedge clk);
            check(downstream_txreq_vld, 1'b1, "downstream_txreq_vld under back-pressure");
            check_ds_req(upd_a, slot_a);
            check(linefill_alloc_rdy, 1'b0, "linefill_alloc_rdy under back-pressure");
        end
        @(posedge clk);
        downstream_txreq_rdy <= 1'b1;
        wait_for(W_LF_RDY, "handshake after release");
        // no buffer slot available
        @(posedge clk);
        linefill_alloc_vld <= 1'b0;
        send_update(upd_b);
        repeat (20) begin
            @(negedge clk);
            check(downstream_txreq_vld, 1'b0, "downstream_txreq_vld without slot");
            check(linefill_alloc_rdy, 1'b0, "linefill_alloc_rdy without slot");
        end
        @(posedge clk);
        linefill_alloc_vld <= 1'b1;
        linefill_alloc_idx <= slot_b;
        wait_for(W_DS, "request after slot release");
        check_ds_req(upd_b, slot_b);
    endtask

    task automatic test_two_reads();
        mshr_types_pkg::mshr_update_t upd_a;
        mshr_types_pkg::mshr_update_t upd_b;
        int                           seen_a;
        int                           seen_b;
        upd_a  = new_update(4, 1'b1, 8'h85, 2'd1);
        upd_b  = new_update(5, 1'b1, 8'h86, 2'd2);
        seen_a = 0;
        seen_b = 0;
        @(posedge clk);
        read_cmd_rdy <= 1'b0;
        send_update(upd_a);
        send_update(upd_b);
        wait_for(W_RD, "held read commands");
        @(posedge clk);
        read_cmd_rdy <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (read_cmd_vld && read_cmd_pld.rob_entry_id == 4) begin
                seen_a++;
                check_cmd(read_cmd_pld, upd_a, "read of entry 4");
            end else if (read_cmd_vld) begin
                seen_b++;
                check_cmd(read_cmd_pld, upd_b, "read of entry 5");
            end
        end
        check(seen_a, 1, "read commands of entry 4");
        check(seen_b, 1, "read commands of entry 5");
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int seed;
        int n;
        errors                    = 0;
        seed                      = $urandom(65);
        alloc_rdy                 = 1'b0;
        mshr_update_en            = 1'b0;
        mshr_update_pld           = '0;
        downstream_txreq_rdy      = 1'b1;
        linefill_alloc_vld        = 1'b1;
        linefill_alloc_idx        = '0;
        ds_txreq_done             = 1'b0;
        ds_txreq_done_idx         = '0;
        ds_txreq_done_db_entry_id = '0;
        linefill_done             = 1'b0;
        linefill_done_idx         = '0;
        rd_done                   = 1'b0;
        rd_done_idx               = '0;
        read_cmd_rdy              = 1'b1;
        write_cmd_rdy_linefill    = 1'b1;

        @(negedge clk);
        check(alloc_vld, 1'b0, "alloc_vld in reset");
        n = 0;
        while (!arst_n && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arst_n) stop_on_error("reset was never released");
        check(downstream_txreq_vld, 1'b0, "downstream_txreq_vld after reset");
        check(read_cmd_vld, 1'b0, "read_cmd_vld after reset");
        check(write_cmd_vld_linefill, 1'b0, "write_cmd_vld_linefill after reset");
        check(linefill_alloc_rdy, 1'b0, "linefill_alloc_rdy after reset");

        test_allocation();
        test_hit_flow();
        test_miss_flow();
        test_back_pressure();
        test_two_reads();

        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/mshr_cfg_pkg.sv
common/mshr_types_pkg.sv
common/mshr_event_if.sv
hdl/rr_arb.sv
hdl/mshr_event_decode.sv
mshr/mshr_pre_alloc.sv
mshr/vec_cache_mshr_entry.sv
mshr/mshr_miss_issue.sv
mshr/vec_cache_mshr.sv
tb/tb_clk_gen.sv
tb/tb_vec_cache_mshr.sv
